//--- list.f
+incdir+common
common/lpi_bridge_pkg.sv
rtl/lpi_req_arbiter.sv
rtl/small_fifo.sv
rtl/lpi_resp_router.sv
rtl/axi_lpi_bridge.sv
bench/lpi_mem_model.sv
bench/tb_axi_lpi_bridge.sv

//--- Bender.yml
package:
  name: axi_lpi_bridge

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lpi_bridge_pkg.sv
      - rtl/lpi_req_arbiter.sv
      - rtl/small_fifo.sv
      - rtl/lpi_resp_router.sv
      - rtl/axi_lpi_bridge.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/lpi_mem_model.sv
      - bench/tb_axi_lpi_bridge.sv

//--- bench/tb_axi_lpi_bridge.sv
`include "lpi_bridge_consts.svh"

module tb_axi_lpi_bridge;

  import lpi_bridge_pkg::*;

  localparam int TIMEOUT = 200;

  logic       clk;
  logic       rst_n;
  axi_addr_t  ar;
  logic       ar_valid;
  logic       ar_ready;
  axi_addr_t  aw;
  logic       aw_valid;
  logic       aw_ready;
  axi_wbeat_t w;
  logic       w_valid;
  logic       w_ready;
  axi_rbeat_t r;
  logic       r_valid;
  logic       r_ready;
  axi_bresp_t b;
  logic       b_valid;
  logic       b_ready;
  lpi_req_t   lpi_req;
  logic       lpi_req_valid;
  logic       lpi_req_ready;
  lpi_resp_t  lpi_resp;
  logic       lpi_resp_valid;
  logic       lpi_resp_ready;
  logic       gap_en;
  logic       wr_open;

  logic [`LPI_DATA_W-1:0] ref_mem [256];
  logic [`LPI_DATA_W-1:0] wr_data [16];
  logic [BEAT_BYTES-1:0]  wr_strb [16];

  axi_lpi_bridge axi_lpi_bridge_inst (.*);

  lpi_mem_model mem_model_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (lpi_req),
    .req_valid  (lpi_req_valid),
    .req_ready  (lpi_req_ready),
    .resp       (lpi_resp),
    .resp_valid (lpi_resp_valid),
    .resp_ready (lpi_resp_ready),
    .gap_en     (gap_en)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ***************************************************************************
  // Failure reporting and compares
  // ***************************************************************************

  task automatic report_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    report_failure();
  endtask

  task automatic check_rbeat(input string test, input axi_rbeat_t exp, input axi_rbeat_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, got %h", test, exp, act);
      report_failure();
    end
  endtask

  task automatic check_bresp(input string test, input axi_bresp_t exp, input axi_bresp_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, got %h", test, exp, act);
      report_failure();
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, got %b", test, exp, act);
      report_failure();
    end
  endtask

  // Write beats of one burst must reach the LPI port back to back
  always @(posedge clk) begin
    if (rst_n && lpi_req_valid && lpi_req_ready) begin
      if (!lpi_req.write && wr_open) begin
        $display("A read request reached the LPI port inside a write burst");
        report_failure();
      end
      if (lpi_req.write) begin
        wr_open = !lpi_req.last;
      end
    end
  end

  // ***************************************************************************
  // Reference memory
  // ***************************************************************************

  function automatic logic [`LPI_DATA_W-1:0] initial_word(input int idx);
    return {8'h3c, 8'(idx), ~8'(idx), 8'(idx) ^ 8'h5a};
  endfunction

  // FIXED keeps the address, INCR steps by one beat
  task automatic ref_write(input logic [`LPI_ADDR_W-1:0] addr, input int len,
                           input axi_burst_e burst);
    logic [`LPI_ADDR_W-1:0] a;
    logic [7:0]             idx;
    int                     k;
    int                     j;
    for (k = 0; k <= len; k++) begin
      a   = (burst == BURST_FIXED) ? addr : addr + 32'(k * BEAT_BYTES);
      idx = a[9:2];
      for (j = 0; j < BEAT_BYTES; j++) begin
        if (wr_strb[k][j]) begin
          ref_mem[idx][8*j +: 8] = wr_data[k][8*j +: 8];
        end
      end
    end
  endtask

  // ***************************************************************************
  // AXI master tasks
  // ***************************************************************************

  task automatic write_burst(input string test, input logic [`LPI_ID_W-1:0] id,
                             input logic [`LPI_ADDR_W-1:0] addr, input int len,
                             input axi_burst_e burst);
    int   beat;
    int   n;
    logic done;
    @(negedge clk);
    aw.id    = id;
    aw.addr  = addr;
    aw.len   = 8'(len);
    aw.size  = 3'd2;
    aw.burst = burst;
    aw_valid = 1'b1;
    for (beat = 0; beat <= len; beat++) begin
      w.data  = wr_data[beat];
      w.strb  = wr_strb[beat];
      w.last  = (beat == len);
      w_valid = 1'b1;
      done    = 1'b0;
      for (n = 0; n < TIMEOUT && !done; n++) begin
        @(posedge clk);
        done = w_ready;
      end
      if (!done) begin
        report_timeout("w_ready");
      end
      // AW completes only with the last beat
      check_flag(test, beat == len, aw_ready);
      @(negedge clk);
    end
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic read_addr(input logic [`LPI_ID_W-1:0] id, input logic [`LPI_ADDR_W-1:0] addr,
                           input int len);
    int   n;
    logic done;
    @(negedge clk);
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = 8'(len);
    ar.size  = 3'd2;
    ar.burst = BURST_INCR;
    ar_valid = 1'b1;
    done     = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge clk);
      done = ar_ready;
    end
    if (!done) begin
      report_timeout("ar_ready");
    end
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic collect_read(input string test, input logic [`LPI_ID_W-1:0] id,
                              input logic [`LPI_ADDR_W-1:0] addr, input int len,
                              input int stall);
    axi_rbeat_t exp;
    logic [7:0] idx;
    int         i;
    int         n;
    logic       done;
    idx = addr[9:2];
    repeat (stall + 1) @(negedge clk);
    r_ready = 1'b1;
    for (i = 0; i <= len; i++) begin
      done = 1'b0;
      for (n = 0; n < TIMEOUT && !done; n++) begin
        @(posedge clk);
        done = r_valid;
      end
      if (!done) begin
        report_timeout("an R beat");
      end
      exp.id   = id;
      exp.data = ref_mem[8'(idx + i)];
      exp.resp = RESP_OKAY;
      exp.last = (i == len);
      check_rbeat(test, exp, r);
    end
    @(negedge clk);
    r_ready = 1'b0;
  endtask

  task automatic wait_bresp(input string test, input logic [`LPI_ID_W-1:0] id);
    axi_bresp_t exp;
    int         n;
    logic       done;
    @(negedge clk);
    b_ready = 1'b1;
    done    = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge clk);
      done = b_valid;
    end
    if (!done) begin
      report_timeout("a B response");
    end
    exp.id   = id;
    exp.resp = RESP_OKAY;
    check_bresp(test, exp, b);
    @(negedge clk);
    b_ready = 1'b0;
  endtask

  task automatic fill_beats(input int len, input logic [BEAT_BYTES-1:0] strb);
    int k;
    for (k = 0; k <= len; k++) begin
      wr_data[k] = $urandom();
      wr_strb[k] = strb;
    end
  endtask

  // ***************************************************************************
  // Directed tests
  // ***************************************************************************

  task automatic test_reset_idle();
    check_flag("reset_idle", 1'b0, r_valid);
    check_flag("reset_idle", 1'b0, b_valid);
    check_flag("reset_idle", 1'b0, lpi_req_valid);
  endtask

  task automatic test_single_write_read();
    fill_beats(0, 4'b0101);
    ref_write(32'h40, 0, BURST_INCR);
    write_burst("single_write_read", 4'h3, 32'h40, 0, BURST_INCR);
    wait_bresp("single_write_read", 4'h3);
    read_addr(4'h5, 32'h40, 0);
    collect_read("single_write_read", 4'h5, 32'h40, 0, 0);
  endtask

  task automatic test_bursts();
    fill_beats(3, 4'hf);
    ref_write(32'h100, 3, BURST_INCR);
    write_burst("incr_burst", 4'h1, 32'h100, 3, BURST_INCR);
    wait_bresp("incr_burst", 4'h1);
    read_addr(4'h2, 32'h100, 3);
    collect_read("incr_burst", 4'h2, 32'h100, 3, 0);
    // Only the final FIXED beat should survive
    fill_beats(2, 4'hf);
    ref_write(32'h200, 2, BURST_FIXED);
    write_burst("fixed_burst", 4'h4, 32'h200, 2, BURST_FIXED);
    wait_bresp("fixed_burst", 4'h4);
    read_addr(4'h8, 32'h200, 0);
    collect_read("fixed_burst", 4'h8, 32'h200, 0, 0);
  endtask

  task automatic test_concurrent();
    fill_beats(3, 4'hf);
    ref_write(32'h300, 3, BURST_INCR);
    fork
      begin
        write_burst("concurrent", 4'h6, 32'h300, 3, BURST_INCR);
        wait_bresp("concurrent", 4'h6);
      end
      begin
        read_addr(4'h7, 32'h100, 3);
        collect_read("concurrent", 4'h7, 32'h100, 3, 0);
      end
    join
    read_addr(4'ha, 32'h300, 3);
    collect_read("concurrent", 4'ha, 32'h300, 3, 0);
  endtask

  task automatic test_backpressure();
    @(negedge clk);
    gap_en = 1'b1;
    fill_beats(3, 4'hf);
    ref_write(32'h180, 3, BURST_INCR);
    write_burst("backpressure", 4'hb, 32'h180, 3, BURST_INCR);
    wait_bresp("backpressure", 4'hb);
    read_addr(4'h9, 32'h180, 3);
    // Long r_ready stall fills the response FIFO
    collect_read("backpressure", 4'h9, 32'h180, 3, 24);
    repeat (4) begin
      @(negedge clk);
      check_flag("backpressure", 1'b0, r_valid);
    end
    gap_en = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hfe89e1ba));
    wr_open  = 1'b0;
    rst_n    = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    gap_en   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = initial_word(i);
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    test_reset_idle();
    test_single_write_read();
    test_bursts();
    test_concurrent();
    test_backpressure();

    $display("Everything OK");
    $finish;
  end

endmodule

//--- bench/lpi_mem_model.sv
`include "lpi_bridge_consts.svh"

module lpi_mem_model (
  input  logic                      clk,
  input  logic                      rst_n,
  input  lpi_bridge_pkg::lpi_req_t  req,
  input  logic                      req_valid,
  output logic                      req_ready,
  output lpi_bridge_pkg::lpi_resp_t resp,
  output logic                      resp_valid,
  input  logic                      resp_ready,
  input  logic                      gap_en
);

  import lpi_bridge_pkg::*;

  logic [`LPI_DATA_W-1:0] mem [256];
  lpi_resp_t              resp_q [$];
  logic                   taken;

  initial begin
    req_ready  = 1'b0;
    resp_valid = 1'b0;
    resp       = '0;
    taken      = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'h3c, 8'(i), ~8'(i), 8'(i) ^ 8'h5a};
    end
  end

  // Writes land byte by byte, reads expand into len+1 beats
  task automatic take_request(input lpi_req_t rq);
    lpi_resp_t  rs;
    logic [7:0] word;
    int         i;
    word     = rq.addr[9:2];
    rs.id    = rq.id;
    rs.write = rq.write;
    rs.resp  = RESP_OKAY;
    rs.data  = '0;
    rs.last  = 1'b1;
    if (rq.write) begin
      for (i = 0; i < BEAT_BYTES; i++) begin
        if (rq.strb[i]) begin
          mem[word][8*i +: 8] = rq.data[8*i +: 8];
        end
      end
      // One response for the whole burst
      if (rq.last) begin
        resp_q.push_back(rs);
      end
    end else begin
      for (i = 0; i <= rq.len; i++) begin
        rs.data = mem[8'(word + i)];
        rs.last = (i == rq.len);
        resp_q.push_back(rs);
      end
    end
  endtask

  always @(posedge clk) begin
    taken = 1'b0;
    if (!rst_n) begin
      resp_q.delete();
    end else begin
      if (resp_valid && resp_ready) begin
        void'(resp_q.pop_front());
        taken = 1'b1;
      end
      if (req_valid && req_ready) begin
        take_request(req);
      end
    end
  end

  // A presented response stays until it is taken
  always @(negedge clk) begin
    if (!rst_n) begin
      req_ready  = 1'b0;
      resp_valid = 1'b0;
      resp       = '0;
    end else begin
      req_ready = gap_en ? ($urandom_range(1, 0) == 1) : 1'b1;
      if (!resp_valid || taken) begin
        resp_valid = (resp_q.size() != 0) && (!gap_en || $urandom_range(1, 0) == 1);
      end
      resp = resp_valid ? resp_q[0] : '0;
    end
  end

endmodule

//--- rtl/axi_lpi_bridge.sv
`include "lpi_bridge_consts.svh"

module axi_lpi_bridge (
  input  logic                       clk,
  input  logic                       rst_n,
  // AXI read address
  input  lpi_bridge_pkg::axi_addr_t  ar,
  input  logic                       ar_valid,
  output logic                       ar_ready,
  // AXI write address and data
  input  lpi_bridge_pkg::axi_addr_t  aw,
  input  logic                       aw_valid,
  output logic                       aw_ready,
  input  lpi_bridge_pkg::axi_wbeat_t w,
  input  logic                       w_valid,
  output logic                       w_ready,
  // AXI responses
  output lpi_bridge_pkg::axi_rbeat_t r,
  output logic                       r_valid,
  input  logic                       r_ready,
  output lpi_bridge_pkg::axi_bresp_t b,
  output logic                       b_valid,
  input  logic                       b_ready,
  // LPI request and response ports
  output lpi_bridge_pkg::lpi_req_t   lpi_req,
  output logic                       lpi_req_valid,
  input  logic                       lpi_req_ready,
  input  lpi_bridge_pkg::lpi_resp_t  lpi_resp,
  input  logic                       lpi_resp_valid,
  output logic                       lpi_resp_ready
);

  import lpi_bridge_pkg::*;

  lpi_req_t  req_in;
  logic      req_in_valid;
  logic      req_in_ready;
  lpi_resp_t resp_out;
  logic      resp_out_valid;
  logic      resp_out_ready;

  lpi_req_arbiter req_arbiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar        (ar),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .req       (req_in),
    .req_valid (req_in_valid),
    .req_ready (req_in_ready)
  );

  small_fifo #(
    .payload_t (lpi_req_t),
    .DEPTH     (`LPI_REQ_DEPTH)
  ) req_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (req_in),
    .in_valid  (req_in_valid),
    .in_ready  (req_in_ready),
    .out_data  (lpi_req),
    .out_valid (lpi_req_valid),
    .out_ready (lpi_req_ready)
  );

  small_fifo #(
    .payload_t (lpi_resp_t),
    .DEPTH     (`LPI_RESP_DEPTH)
  ) resp_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (lpi_resp),
    .in_valid  (lpi_resp_valid),
    .in_ready  (lpi_resp_ready),
    .out_data  (resp_out),
    .out_valid (resp_out_valid),
    .out_ready (resp_out_ready)
  );

  lpi_resp_router resp_router_inst (
    .resp       (resp_out),
    .resp_valid (resp_out_valid),
    .resp_ready (resp_out_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .b          (b),
    .b_valid    (b_valid),
    .b_ready    (b_ready)
  );

endmodule

//--- rtl/lpi_resp_router.sv
module lpi_resp_router (
  input  lpi_bridge_pkg::lpi_resp_t  resp,
  input  logic                       resp_valid,
  output logic                       resp_ready,
  output lpi_bridge_pkg::axi_rbeat_t r,
  output logic                       r_valid,
  input  logic                       r_ready,
  output lpi_bridge_pkg::axi_bresp_t b,
  output logic                       b_valid,
  input  logic                       b_ready
);

  // ***************************************************************************
  // Channel select
  // ***************************************************************************

  // The head decides the channel, so responses leave in arrival order
  assign r_valid = resp_valid & ~resp.write;
  assign b_valid = resp_valid & resp.write;

  // Pop with the ready of the channel that owns the head
  assign resp_ready = resp.write ? b_ready : r_ready;

  // ***************************************************************************
  // Payload mapping
  // ***************************************************************************

  // Read beat keeps the last flag from the slave
  always_comb begin
    r.id   = resp.id;
    r.data = resp.data;
    r.resp = resp.resp;
    r.last = resp.last;
  end

  // One B response per write burst and no data
  always_comb begin
    b.id   = resp.id;
    b.resp = resp.resp;
  end

endmodule

//--- rtl/small_fifo.sv
module small_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Full refuses a push even in a cycle that pops
  assign in_ready  = (count < CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // ***************************************************************************
  // Pointers and occupancy
  // ***************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // A full FIFO never moves its write pointer
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    (count == CNT_W'(DEPTH)) |=> $stable(wr_ptr))
    else $error("push accepted while FIFO full");

  // Head word must hold until it is taken
  a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("FIFO head changed while stalled");

endmodule

//--- rtl/lpi_req_arbiter.sv
`include "lpi_bridge_consts.svh"

module lpi_req_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  lpi_bridge_pkg::axi_addr_t  ar,
  input  logic                       ar_valid,
  output logic                       ar_ready,
  input  lpi_bridge_pkg::axi_addr_t  aw,
  input  logic                       aw_valid,
  output logic                       aw_ready,
  input  lpi_bridge_pkg::axi_wbeat_t w,
  input  logic                       w_valid,
  output logic                       w_ready,
  output lpi_bridge_pkg::lpi_req_t   req,
  output logic                       req_valid,
  input  logic                       req_ready
);

  import lpi_bridge_pkg::*;

  localparam int unsigned BEAT_SHIFT = $clog2(BEAT_BYTES);

  logic                   rd_pend;
  logic                   wr_pend;
  logic                   sel_wr;
  logic                   rd_hs;
  logic                   wr_hs;
  logic                   grant_wr;
  logic                   wr_busy;
  logic [7:0]             beat_cnt;
  logic [`LPI_ADDR_W-1:0] beat_offset;
  logic [`LPI_ADDR_W-1:0] wr_addr;

  assign rd_pend = ar_valid;
  assign wr_pend = aw_valid & w_valid;

  // Inside a write burst the write keeps the grant, otherwise the side
  // that was not served last wins a tie
  assign sel_wr = wr_busy | (wr_pend & (~rd_pend | ~grant_wr));

  assign ar_ready = ~sel_wr & req_ready;
  assign w_ready  = sel_wr & aw_valid & req_ready;
  // AW is held by the master until the last W beat goes through
  assign aw_ready = w_ready & w_valid & w.last;

  assign rd_hs = ar_valid & ar_ready;
  assign wr_hs = w_valid & w_ready;

  assign req_valid = sel_wr ? wr_pend : rd_pend;

  // ***************************************************************************
  // Per-beat write address
  // ***************************************************************************

  assign beat_offset = {{(`LPI_ADDR_W - 8){1'b0}}, beat_cnt} << BEAT_SHIFT;
  assign wr_addr     = (aw.burst == BURST_FIXED) ? aw.addr : aw.addr + beat_offset;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant_wr <= 1'b0;
      wr_busy  <= 1'b0;
      beat_cnt <= '0;
    end else if (wr_hs) begin
      grant_wr <= 1'b1;
      if (w.last) begin
        wr_busy  <= 1'b0;
        beat_cnt <= '0;
      end else begin
        wr_busy  <= 1'b1;
        beat_cnt <= beat_cnt + 8'd1;
      end
    end else if (rd_hs) begin
      grant_wr <= 1'b0;
    end
  end

  // ***************************************************************************
  // Request packet
  // ***************************************************************************

  always_comb begin
    req.write = sel_wr;
    if (sel_wr) begin
      req.id    = aw.id;
      req.addr  = wr_addr;
      req.len   = aw.len;
      req.size  = aw.size;
      req.burst = aw.burst;
      req.strb  = w.strb;
      req.data  = w.data;
      req.last  = w.last;
    end else begin
      req.id    = ar.id;
      req.addr  = ar.addr;
      req.len   = ar.len;
      req.size  = ar.size;
      req.burst = ar.burst;
      // A read is a single packet for the whole burst
      req.strb  = '0;
      req.data  = '0;
      req.last  = 1'b1;
    end
  end

  // An open write burst must keep reads out until its last beat
  a_burst_held: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_hs && !w.last) |=> !ar_ready)
    else $error("read granted inside a write burst");

endmodule

//--- common/lpi_bridge_pkg.sv
`include "lpi_bridge_consts.svh"

package lpi_bridge_pkg;

  // Bytes in one data beat, used for strobes and address stepping
  localparam int unsigned BEAT_BYTES = `LPI_DATA_W / 8;

  // ***************************************************************************
  // AXI encodings
  // ***************************************************************************

  // WRAP is accepted but stepped like INCR
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  // ***************************************************************************
  // AXI channels
  // ***************************************************************************

  // Shared by AR and AW
  typedef struct packed {
    logic [`LPI_ID_W-1:0]   id;
    logic [`LPI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    axi_burst_e             burst;
  } axi_addr_t;

  typedef struct packed {
    logic [`LPI_DATA_W-1:0] data;
    logic [BEAT_BYTES-1:0]  strb;
    logic                   last;
  } axi_wbeat_t;

  typedef struct packed {
    logic [`LPI_ID_W-1:0]   id;
    logic [`LPI_DATA_W-1:0] data;
    axi_resp_e              resp;
    logic                   last;
  } axi_rbeat_t;

  typedef struct packed {
    logic [`LPI_ID_W-1:0] id;
    axi_resp_e            resp;
  } axi_bresp_t;

  // ***************************************************************************
  // LPI packets
  // ***************************************************************************

  // One packet per read burst, one per write beat
  typedef struct packed {
    logic [`LPI_ID_W-1:0]   id;
    logic                   write;
    logic [`LPI_ADDR_W-1:0] addr;
    logic [7:0]             len;
    logic [2:0]             size;
    axi_burst_e             burst;
    logic [BEAT_BYTES-1:0]  strb;
    logic [`LPI_DATA_W-1:0] data;
    logic                   last;
  } lpi_req_t;

  typedef struct packed {
    logic [`LPI_ID_W-1:0]   id;
    logic                   write;
    axi_resp_e              resp;
    logic [`LPI_DATA_W-1:0] data;
    logic                   last;
  } lpi_resp_t;

endpackage

//--- common/lpi_bridge_consts.svh
`ifndef LPI_BRIDGE_CONSTS_SVH
`define LPI_BRIDGE_CONSTS_SVH

// ***************************************************************************
// Bus widths
// ***************************************************************************

// Byte address on both the AXI and the LPI side
`define LPI_ADDR_W 32

// One data beat, strobes are derived from this
`define LPI_DATA_W 32

// Transaction id, carried through to R and B unchanged
`define LPI_ID_W 4

// ***************************************************************************
// Buffer depths
// ***************************************************************************

// Request FIFO between arbiter and LPI request port
`define LPI_REQ_DEPTH 2

// Response FIFO between LPI response port and router
`define LPI_RESP_DEPTH 3

`endif
